// ==== build.f ====
+incdir+verilog
verilog/dma_pkg.sv
verilog/dma_regs.sv
verilog/dma_frame_fsm.sv
verilog/dma_frame_counter.sv
verilog/dma_swap_slice.sv
verilog/dma_tx_top.sv
verif/dma_tx_props.sv
verif/dma_tx_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dma_tx_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/dma_tx_tb.sv ====
/*
 * Testbench for the DMA TX framer. Drives the register port and the sample stream
 * and checks every output sample against a reference model of the framing rule.
 */
`include "dma_config.svh"

module dma_tx_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 2000;  // Cycles per wait

    logic              clk;
    logic              i_rst_n;
    dma_pkg::reg_req_t i_reg;
    dma_pkg::reg_rsp_t o_reg;
    dma_pkg::sample_u  i_s_data;
    logic              i_s_valid;
    logic              o_s_ready;
    dma_pkg::sample_u  o_m_data;
    logic              o_m_last;
    logic              o_m_valid;
    logic              i_m_ready;

    logic [31:0] lfsr = 32'h663cc655;
    logic [63:0] stim [$];
    logic [64:0] expq [$];  // {last, word}
    logic        random_ready;
    int          sent_total;
    int          sent_lasts;

    dma_tx_top i_dut (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_reg     (i_reg),
        .o_reg     (o_reg),
        .i_s_data  (i_s_data),
        .i_s_valid (i_s_valid),
        .o_s_ready (o_s_ready),
        .o_m_data  (o_m_data),
        .o_m_last  (o_m_last),
        .o_m_valid (o_m_valid),
        .i_m_ready (i_m_ready)
    );

    always #2 clk = ~clk;

    // Fibonacci taps 32, 22, 2, 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_word();
        logic [63:0] w;
        w = '0;
        for (int i = 0; i < 64; i++) begin
            w = {w[62:0], next_bit()};
        end
        return w;
    endfunction

    // Sample idx counts from the start of a frame-aligned burst
    function automatic logic [64:0] expected_sample(int idx, int size, logic swap,
                                                    logic [63:0] data);
        logic        last;
        logic [63:0] word;
        last = ((idx + 1) % size) == 0;
        word = swap ? {data[31:0], data[63:32]} : data;
        return {last, word};
    endfunction

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic wait_reg_ready();
        int n;
        n = 0;
        while (!o_reg.rdy) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) fail_run("Timeout waiting for the register port to be ready");
        end
    endtask

    task automatic reg_write(logic [19:0] addr, logic [31:0] data);
        @(negedge clk);
        i_reg = '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
        wait_reg_ready();
        @(negedge clk);  // Accepted on the rising edge in between
        i_reg.wr = 1'b0;
    endtask

    task automatic reg_read(logic [19:0] addr, output logic [31:0] data);
        int n;
        @(negedge clk);
        i_reg = '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: '0};
        wait_reg_ready();
        @(negedge clk);
        i_reg.rd = 1'b0;
        n = 0;
        while (!o_reg.rc) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) fail_run("Timeout waiting for the read to complete");
        end
        data = o_reg.rdata;
    endtask

    task automatic check_reg(logic [19:0] addr, logic [31:0] want);
        logic [31:0] val;
        reg_read(addr, val);
        assert (val == want)
        else fail_run($sformatf("[ERROR] o_reg.rdata @%h: expected %h, got %h",
                                addr, want, val));
    endtask

    task automatic fill_stim(int n);
        for (int i = 0; i < n; i++) begin
            stim.push_back(rand_word());
        end
    endtask

    task automatic send_stim(int size, logic swap);
        int          idx;
        int          n;
        logic [63:0] data;
        logic [64:0] want;
        idx = 0;
        @(negedge clk);
        while (stim.size() > 0) begin
            data = stim.pop_front();
            want = expected_sample(idx, size, swap, data);
            expq.push_back(want);
            if (want[64]) sent_lasts++;
            i_s_data.word = data;
            i_s_valid = 1'b1;
            n = 0;
            while (!o_s_ready) begin
                @(negedge clk);
                n++;
                if (n > TIMEOUT) fail_run("Timeout waiting for the input stream to accept");
            end
            @(negedge clk);
            idx++;
            sent_total++;
        end
        i_s_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (expq.size() > 0) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) fail_run("Timeout waiting for the output stream to drain");
        end
    endtask

    always @(negedge clk) begin
        if (random_ready) i_m_ready = next_bit();
        else i_m_ready = 1'b1;
    end

    // Compare each output transfer with the head of the expected queue
    always @(posedge clk) begin
        logic [64:0] want;
        if (i_rst_n && o_m_valid && i_m_ready) begin
            assert (expq.size() > 0)
            else fail_run("Output transfer with no sample outstanding");
            want = expq.pop_front();
            assert (o_m_data.word == want[63:0])
            else fail_run($sformatf("[ERROR] o_m_data: expected %h, got %h",
                                    want[63:0], o_m_data.word));
            assert (o_m_last == want[64])
            else fail_run($sformatf("[ERROR] o_m_last: expected %h, got %h",
                                    want[64], o_m_last));
        end
    end

    initial begin
        clk          = 1'b0;
        i_rst_n      = 1'b0;
        i_reg        = '0;
        i_s_data     = '0;
        i_s_valid    = 1'b0;
        i_m_ready    = 1'b1;
        random_ready = 1'b0;
        sent_total   = 0;
        sent_lasts   = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;
        assert (!o_m_valid && !o_reg.rc && o_reg.rdy && o_s_ready)
        else fail_run("Outputs are not in their reset state");

        check_reg(`REG_SIGNATURE, `SIGNATURE_VAL);
        reg_write(`REG_SCRATCH0, 32'hdead_beef);
        reg_write(`REG_SCRATCH1, 32'h0123_4567);
        check_reg(`REG_SCRATCH0, 32'hdead_beef);
        check_reg(`REG_SCRATCH1, 32'h0123_4567);
        check_reg(20'h100, 32'h0);  // Unmapped

        check_reg(`REG_FRAME_SIZE, 32'd32);
        fill_stim(64);
        send_stim(32, 1'b0);
        wait_drain();

        reg_write(`REG_FRAME_SIZE, 32'd16);
        check_reg(`REG_FRAME_SIZE, 32'd16);
        fill_stim(48);
        send_stim(16, 1'b0);
        wait_drain();

        // Half swap on, then off again
        reg_write(`REG_CTRL, 32'h10);
        check_reg(`REG_CTRL, 32'h10);
        fill_stim(32);
        send_stim(16, 1'b1);
        wait_drain();
        reg_write(`REG_CTRL, 32'h0);
        fill_stim(16);
        send_stim(16, 1'b0);
        wait_drain();

        check_reg(`REG_SAMPLE_CNT, sent_total);
        check_reg(`REG_PACKET_CNT, sent_lasts);
        reg_write(`REG_SAMPLE_CNT, 32'hffff_ffff);
        reg_write(`REG_PACKET_CNT, 32'h1);
        check_reg(`REG_SAMPLE_CNT, 32'h0);
        check_reg(`REG_PACKET_CNT, 32'h0);

        // Random back-pressure; data drawn before the ready process starts using the LFSR
        fill_stim(48);
        random_ready = 1'b1;
        send_stim(16, 1'b0);
        wait_drain();
        random_ready = 1'b0;
        check_reg(`REG_SAMPLE_CNT, 32'd48);
        check_reg(`REG_PACKET_CNT, 32'd3);

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== verif/dma_tx_props.sv ====
/*
 * Handshake assertions for the DMA TX framer, bound into the top level.
 */
module dma_tx_props (
    input logic              clk,
    input logic              i_rst_n,
    input dma_pkg::reg_req_t i_reg,
    input dma_pkg::reg_rsp_t o_reg,
    input dma_pkg::sample_u  o_m_data,
    input logic              o_m_last,
    input logic              o_m_valid,
    input logic              i_m_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    // Stalled output keeps its sample
    assert property (@(posedge clk) disable iff (!i_rst_n)
        o_m_valid && !i_m_ready |=> o_m_valid && $stable(o_m_data) && $stable(o_m_last))
    else $error("output sample dropped or changed while stalled");

    assert property (@(posedge clk) disable iff (!i_rst_n)
        i_reg.rd && o_reg.rdy |=> o_reg.rc)
    else $error("read accepted without a completion on the next cycle");

    assert property (@(posedge clk) disable iff (!i_rst_n) o_reg.rc |=> !o_reg.rc)
    else $error("read completion longer than one cycle");

    assert property (@(posedge clk) disable iff (!i_rst_n) o_reg.rc |-> !o_reg.rdy)
    else $error("register port ready during read completion");

endmodule

bind dma_tx_top dma_tx_props u_props (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_reg     (i_reg),
    .o_reg     (o_reg),
    .o_m_data  (o_m_data),
    .o_m_last  (o_m_last),
    .o_m_valid (o_m_valid),
    .i_m_ready (i_m_ready)
);

// ==== verilog/dma_tx_top.sv ====
/*
 * Single-channel host-to-device DMA framer. Cuts an unbounded sample stream
 * into frames of a programmable size, with register access to its settings.
 */
`include "dma_config.svh"

module dma_tx_top (
    input  logic              clk,
    input  logic              i_rst_n,
    input  dma_pkg::reg_req_t i_reg,
    output dma_pkg::reg_rsp_t o_reg,
    input  dma_pkg::sample_u  i_s_data,
    input  logic              i_s_valid,
    output logic              o_s_ready,
    output dma_pkg::sample_u  o_m_data,
    output logic              o_m_last,
    output logic              o_m_valid,
    input  logic              i_m_ready
);

    dma_pkg::dma_cfg_t   cfg;
    dma_pkg::dma_stat_t  stat;
    logic                clr_samples;
    logic                clr_packets;
    logic                accept;
    logic                m_fire;
    logic                load;
    logic                frame_end;
    logic [`FRAME_W-1:0] size;

    assign accept = i_s_valid & o_s_ready;
    assign m_fire = o_m_valid & i_m_ready;

    dma_regs u_regs (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_reg         (i_reg),
        .o_reg         (o_reg),
        .i_stat        (stat),
        .o_cfg         (cfg),
        .o_clr_samples (clr_samples),
        .o_clr_packets (clr_packets)
    );

    dma_frame_fsm u_fsm (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_accept    (accept),
        .i_cfg       (cfg),
        .i_frame_end (frame_end),
        .o_load      (load),
        .o_size      (size)
    );

    dma_frame_counter u_counter (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_accept      (accept),
        .i_load        (load),
        .i_size        (size),
        .i_out_fire    (m_fire),
        .i_out_last    (o_m_last),
        .i_clr_samples (clr_samples),
        .i_clr_packets (clr_packets),
        .o_frame_end   (frame_end),
        .o_stat        (stat)
    );

    // frame_end rides along as tlast
    dma_swap_slice u_slice (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_accept  (accept),
        .i_data    (i_s_data),
        .i_last    (frame_end),
        .i_swap    (cfg.swap),
        .o_ready   (o_s_ready),
        .o_data    (o_m_data),
        .o_last    (o_m_last),
        .o_valid   (o_m_valid),
        .i_m_ready (i_m_ready)
    );

endmodule

// ==== verilog/dma_swap_slice.sv ====
/*
 * Two-entry output buffer. Stores each accepted sample, halves exchanged
 * when swap is on, with its last flag, and drains in order.
 */
module dma_swap_slice (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_accept,
    input  dma_pkg::sample_u  i_data,
    input  logic              i_last,
    input  logic              i_swap,
    output logic              o_ready,
    output dma_pkg::sample_u  o_data,
    output logic              o_last,
    output logic              o_valid,
    input  logic              i_m_ready
);

    dma_pkg::sample_u mem_data [2];
    logic             mem_last [2];
    logic             wr_ptr;
    logic             rd_ptr;
    logic [1:0]       count_q;
    dma_pkg::sample_u swapped;
    logic             out_fire;

    always_comb begin
        swapped = i_data;
        if (i_swap) begin
            swapped.half.hi = i_data.half.lo;
            swapped.half.lo = i_data.half.hi;
        end
    end

    assign o_ready  = (count_q != 2'd2);
    assign o_valid  = (count_q != 2'd0);
    assign o_data   = mem_data[rd_ptr];
    assign o_last   = mem_last[rd_ptr];
    assign out_fire = o_valid & i_m_ready;

    always_ff @(posedge clk) begin
        if (i_accept) begin
            mem_data[wr_ptr] <= swapped;
            mem_last[wr_ptr] <= i_last;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr  <= 1'b0;
            rd_ptr  <= 1'b0;
            count_q <= 2'd0;
        end else begin
            if (i_accept) wr_ptr <= ~wr_ptr;
            if (out_fire) rd_ptr <= ~rd_ptr;
            case ({i_accept, out_fire})
                2'b10:   count_q <= count_q + 2'd1;
                2'b01:   count_q <= count_q - 2'd1;
                default: count_q <= count_q;  // Both or neither
            endcase
        end
    end

endmodule

// ==== verilog/dma_frame_counter.sv ====
/*
 * Frame position counter and output totals. Flags the last sample of a
 * frame at accept time and counts samples and packets leaving the design.
 */
`include "dma_config.svh"

module dma_frame_counter (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_accept,
    input  logic                i_load,
    input  logic [`FRAME_W-1:0] i_size,
    input  logic                i_out_fire,
    input  logic                i_out_last,
    input  logic                i_clr_samples,
    input  logic                i_clr_packets,
    output logic                o_frame_end,
    output dma_pkg::dma_stat_t  o_stat
);

    logic [`FRAME_W-1:0] pos_q;    // Samples already taken in this frame
    logic [`FRAME_W-1:0] pos_cur;
    logic [31:0]         sample_cnt_q;
    logic [31:0]         packet_cnt_q;

    // Position of the sample being accepted, counted from 1
    assign pos_cur     = (i_load ? '0 : pos_q) + 1'b1;
    assign o_frame_end = i_accept && (pos_cur == i_size);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pos_q <= '0;
        end else if (i_accept) begin
            pos_q <= o_frame_end ? '0 : pos_cur;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sample_cnt_q <= '0;
            packet_cnt_q <= '0;
        end else begin
            if (i_clr_samples) begin
                sample_cnt_q <= '0;
            end else if (i_out_fire) begin
                sample_cnt_q <= sample_cnt_q + 1'b1;
            end

            if (i_clr_packets) begin
                packet_cnt_q <= '0;
            end else if (i_out_fire && i_out_last) begin
                packet_cnt_q <= packet_cnt_q + 1'b1;
            end
        end
    end

    assign o_stat = '{sample_cnt: sample_cnt_q, packet_cnt: packet_cnt_q};

endmodule

// ==== verilog/dma_frame_fsm.sv ====
/*
 * Frame boundary tracker. Latches the configured frame size on the first
 * accepted sample of each frame and hands it to the position counter.
 */
`include "dma_config.svh"

module dma_frame_fsm (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_accept,
    input  dma_pkg::dma_cfg_t   i_cfg,
    input  logic                i_frame_end,
    output logic                o_load,
    output logic [`FRAME_W-1:0] o_size
);

    dma_pkg::frame_state_e state_q;
    dma_pkg::frame_state_e state_d;
    logic [`FRAME_W-1:0]   size_q;

    // First sample of a frame sees the live size
    assign o_load = i_accept && (state_q == dma_pkg::IDLE);
    assign o_size = o_load ? i_cfg.frame_size : size_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            dma_pkg::IDLE: begin
                if (o_load && !i_frame_end) begin  // Single-sample frames stay here
                    state_d = dma_pkg::STREAM;
                end
            end
            dma_pkg::STREAM: begin
                if (i_accept && i_frame_end) begin
                    state_d = dma_pkg::IDLE;
                end
            end
            default: state_d = dma_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= dma_pkg::IDLE;
            size_q  <= `FRAME_DEFAULT;
        end else begin
            state_q <= state_d;
            if (o_load) begin
                size_q <= i_cfg.frame_size;
            end
        end
    end

endmodule

// ==== verilog/dma_regs.sv ====
/*
 * Register file behind the strobe/ready register port. Holds signature,
 * scratch, frame size and control, and answers reads one cycle after accept.
 */
`include "dma_config.svh"

module dma_regs (
    input  logic                clk,
    input  logic                i_rst_n,
    input  dma_pkg::reg_req_t   i_reg,
    output dma_pkg::reg_rsp_t   o_reg,
    input  dma_pkg::dma_stat_t  i_stat,
    output dma_pkg::dma_cfg_t   o_cfg,
    output logic                o_clr_samples,
    output logic                o_clr_packets
);

    logic                   wr_acc;
    logic                   rd_acc;
    logic                   rc_q;
    logic [`REG_DATA_W-1:0] rd_mux;
    logic [`REG_DATA_W-1:0] rdata_q;
    logic [`REG_DATA_W-1:0] scratch0_q;
    logic [`REG_DATA_W-1:0] scratch1_q;
    logic [`FRAME_W-1:0]    frame_size_q;
    logic                   swap_q;

    // Port is busy only in the response cycle
    assign wr_acc = i_reg.wr & ~rc_q;
    assign rd_acc = i_reg.rd & ~rc_q;

    // Counter clears land on the accepting edge
    assign o_clr_samples = wr_acc && (i_reg.addr == `REG_SAMPLE_CNT);
    assign o_clr_packets = wr_acc && (i_reg.addr == `REG_PACKET_CNT);

    always_comb begin
        rd_mux = '0;
        case (i_reg.addr)
            `REG_SIGNATURE:  rd_mux = `SIGNATURE_VAL;
            `REG_SCRATCH0:   rd_mux = scratch0_q;
            `REG_SCRATCH1:   rd_mux = scratch1_q;
            `REG_FRAME_SIZE: rd_mux[`FRAME_W-1:0] = frame_size_q;
            `REG_CTRL:       rd_mux[`CTRL_SWAP_BIT] = swap_q;
            `REG_SAMPLE_CNT: rd_mux = i_stat.sample_cnt;
            `REG_PACKET_CNT: rd_mux = i_stat.packet_cnt;
            default:         rd_mux = '0;  // Unmapped
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            scratch0_q   <= '0;
            scratch1_q   <= '0;
            frame_size_q <= `FRAME_DEFAULT;
            swap_q       <= 1'b0;
        end else if (wr_acc) begin
            case (i_reg.addr)
                `REG_SCRATCH0:   scratch0_q   <= i_reg.wdata;
                `REG_SCRATCH1:   scratch1_q   <= i_reg.wdata;
                `REG_FRAME_SIZE: frame_size_q <= i_reg.wdata[`FRAME_W-1:0];
                `REG_CTRL:       swap_q       <= i_reg.wdata[`CTRL_SWAP_BIT];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rc_q <= 1'b0;
        end else begin
            rc_q <= rd_acc;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_acc) begin
            rdata_q <= rd_mux;
        end
    end

    assign o_reg = '{rc: rc_q, rdy: ~rc_q, rdata: rdata_q};
    assign o_cfg = '{frame_size: frame_size_q, swap: swap_q};

endmodule

// ==== verilog/dma_pkg.sv ====
/*
 * Shared types of the framer: register port bundles, the sample word,
 * configuration and status structs, and the frame FSM states.
 */
`include "dma_config.svh"

package dma_pkg;

    typedef struct packed {
        logic                   wr;
        logic                   rd;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`REG_DATA_W-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic                   rc;     // Read complete, one cycle
        logic                   rdy;
        logic [`REG_DATA_W-1:0] rdata;
    } reg_rsp_t;

    typedef struct packed {
        logic [`DMA_HALF_W-1:0] hi;
        logic [`DMA_HALF_W-1:0] lo;
    } sample_halves_t;

    // Same 64 bits, whole or split for the half swap
    typedef union packed {
        logic [`DMA_DATA_W-1:0] word;
        sample_halves_t         half;
    } sample_u;

    typedef struct packed {
        logic [`FRAME_W-1:0] frame_size;
        logic                swap;
    } dma_cfg_t;

    typedef struct packed {
        logic [31:0] sample_cnt;
        logic [31:0] packet_cnt;
    } dma_stat_t;

    typedef enum logic {
        IDLE,
        STREAM
    } frame_state_e;

endpackage

// ==== verilog/dma_config.svh ====
/*
 * Widths, reset defaults and register map of the DMA TX framer.
 * Included by the package and by every module that needs a width or an offset.
 */
`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

`define DMA_DATA_W      64
`define DMA_HALF_W      32
`define REG_ADDR_W      20
`define REG_DATA_W      32
`define FRAME_W         16
`define FRAME_DEFAULT   16'd32

`define REG_SIGNATURE   20'h000
`define REG_SCRATCH0    20'h010
`define REG_SCRATCH1    20'h014
`define REG_FRAME_SIZE  20'h204
`define REG_CTRL        20'h208
`define REG_SAMPLE_CNT  20'h218
`define REG_PACKET_CNT  20'h22C

`define CTRL_SWAP_BIT   4
`define SIGNATURE_VAL   32'h5833_3030  // ASCII "X300"

`endif
